// File: alu.sv
`timescale 1ns/1ps
`include "riscv_consts.svh"

module alu (
    input  riscv_pkg::word_t   rs1_data,
    input  riscv_pkg::word_t   rs2_data,
    input  riscv_pkg::word_t   pc,
    input  riscv_pkg::word_t   imm,
    input  logic               src_a_pc,
    input  logic               src_b_imm,
    input  riscv_pkg::alu_op_t alu_op,
    output riscv_pkg::word_t   alu_result
);
    import riscv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    assign op_a  = src_a_pc ? pc : rs1_data;
    assign op_b  = src_b_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            // sign bit fills from the left
            SRA:     alu_result = word_t'($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = op_b;
        endcase
    end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  riscv_pkg::word_t   rs1_data,
    input  riscv_pkg::word_t   rs2_data,
    input  riscv_pkg::word_t   pc,
    input  riscv_pkg::word_t   imm,
    input  riscv_pkg::funct3_t funct3,
    input  logic               is_branch,
    output logic               branch_taken,
    output riscv_pkg::word_t   branch_target
);

    logic cond;

    always_comb begin
        case (funct3)
            3'b000:  cond = rs1_data == rs2_data;
            3'b001:  cond = rs1_data != rs2_data;
            3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  cond = rs1_data < rs2_data;
            3'b111:  cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken  = is_branch && cond;
    assign branch_target = pc + imm;

    // imm bit 1 may be set, so a bad program can jump off-word
    always_comb begin
        if (branch_taken) begin
            target_aligned: assert final (branch_target[1:0] == 2'b00)
                else $error("taken branch to unaligned address %h", branch_target);
        end
    end

endmodule

// File: core_ctrl.sv
`timescale 1ns/1ps
`include "riscv_consts.svh"

module core_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_ack,
    input  riscv_pkg::word_t    inst,
    input  riscv_pkg::word_t    alu_result,
    input  logic                branch_taken,
    input  riscv_pkg::word_t    branch_target,
    input  logic                writes_rd,
    input  logic                is_system,
    input  riscv_pkg::reg_idx_t rd_num,
    output logic                fetch_req,
    output riscv_pkg::word_t    fetch_addr,
    output riscv_pkg::word_t    inst_reg,
    output riscv_pkg::word_t    pc,
    output logic                rd_we,
    output riscv_pkg::word_t    rd_data,
    output logic                retire_valid,
    output riscv_pkg::word_t    retire_pc,
    output logic                retire_we,
    output riscv_pkg::reg_idx_t retire_rd,
    output riscv_pkg::word_t    retire_data,
    output logic                halted
);
    import riscv_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    word_t       pc_next;

    always_comb begin
        state_next = state;
        case (state)
            FETCH_REQ: begin
                if (fetch_ack) begin
                    state_next = EXECUTE;
                end
            end
            EXECUTE: begin
                // request again at once if memory has already dropped ack
                if (is_system) begin
                    state_next = HALT;
                end else if (fetch_ack) begin
                    state_next = FETCH_RELEASE;
                end else begin
                    state_next = FETCH_REQ;
                end
            end
            FETCH_RELEASE: begin
                // wait for memory to finish the handshake
                if (!fetch_ack) begin
                    state_next = FETCH_REQ;
                end
            end
            default: begin
                state_next = HALT;
            end
        endcase
    end

    assign pc_next = branch_taken ? branch_target : pc + `PC_STEP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_REQ;
            pc    <= `RESET_PC;
        end else begin
            state <= state_next;
            if (state == EXECUTE) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_REQ && fetch_ack) begin
            inst_reg <= inst;
        end
    end

    assign fetch_req  = state == FETCH_REQ;
    assign fetch_addr = pc;

    assign retire_valid = state == EXECUTE;
    assign rd_we        = retire_valid && writes_rd;
    assign rd_data      = alu_result;
    assign retire_pc    = pc;
    assign retire_we    = rd_we;
    assign retire_rd    = rd_num;
    assign retire_data  = alu_result;
    assign halted       = state == HALT;

    req_waits_for_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(fetch_req) |-> !$past(fetch_ack));

    single_cycle_retire: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |=> !retire_valid);

endmodule

// File: filelist.f
+incdir+.
riscv_pkg.sv
reg_file.sv
instr_decode.sv
alu.sv
branch_unit.sv
core_ctrl.sv
riscv_core.sv
tb_clock_gen.sv
tb_riscv_core.sv

// File: instr_decode.sv
`timescale 1ns/1ps
`include "riscv_consts.svh"

module instr_decode (
    input  riscv_pkg::word_t    inst,
    output riscv_pkg::reg_idx_t rs1_num,
    output riscv_pkg::reg_idx_t rs2_num,
    output riscv_pkg::reg_idx_t rd_num,
    output riscv_pkg::word_t    imm,
    output riscv_pkg::alu_op_t  alu_op,
    output logic                src_a_pc,
    output logic                src_b_imm,
    output logic                writes_rd,
    output logic                is_branch,
    output logic                is_system,
    output riscv_pkg::funct3_t  funct3
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic       funct7_alt;
    word_t      imm_i;
    word_t      imm_sh;
    word_t      imm_u;
    word_t      imm_b;
    alu_op_t    base_op;

    assign opcode     = inst[6:0];
    assign funct7_alt = inst[30];
    assign rs1_num    = inst[19:15];
    assign rs2_num    = inst[24:20];
    assign rd_num     = inst[11:7];
    assign funct3     = inst[14:12];

    assign imm_i  = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_sh = {{(`XLEN-5){1'b0}}, inst[24:20]};
    assign imm_u  = {inst[31:12], 12'b0};
    assign imm_b  = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // funct3 map shared by both alu groups
    always_comb begin
        case (funct3)
            3'b000:  base_op = ADD;
            3'b001:  base_op = SLL;
            3'b010:  base_op = SLT;
            3'b011:  base_op = SLTU;
            3'b100:  base_op = XOR;
            3'b101:  base_op = funct7_alt ? SRA : SRL;
            3'b110:  base_op = OR;
            default: base_op = AND;
        endcase
    end

    always_comb begin
        imm       = '0;
        alu_op    = ADD;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        is_system = 1'b0;
        case (opcode)
            `OP_REG: begin
                writes_rd = 1'b1;
                alu_op    = (funct3 == 3'b000 && funct7_alt) ? SUB : base_op;
            end
            `OP_IMM: begin
                writes_rd = 1'b1;
                src_b_imm = 1'b1;
                alu_op    = base_op;
                // slli/srli/srai carry only a shift amount
                imm = (funct3 == 3'b001 || funct3 == 3'b101) ? imm_sh : imm_i;
            end
            `OP_LUI: begin
                writes_rd = 1'b1;
                src_b_imm = 1'b1;
                alu_op    = PASS_B;
                imm       = imm_u;
            end
            `OP_AUIPC: begin
                writes_rd = 1'b1;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                imm       = imm_u;
            end
            `OP_BRANCH: begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            `OP_SYSTEM: begin
                is_system = 1'b1;
            end
            default: begin
                // unknown opcode retires as a no-op
                writes_rd = 1'b0;
            end
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "riscv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  riscv_pkg::reg_idx_t rs1_num,
    input  riscv_pkg::reg_idx_t rs2_num,
    input  riscv_pkg::reg_idx_t rd_num,
    input  logic                rd_we,
    input  riscv_pkg::word_t    rd_data,
    output riscv_pkg::word_t    rs1_data,
    output riscv_pkg::word_t    rs2_data
);
    import riscv_pkg::*;

    word_t regs [`REG_COUNT];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_num != '0) begin
            regs[rd_num] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_num];
    assign rs2_data = regs[rs2_num];

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_num != '0 || rs1_data == '0) && (rs2_num != '0 || rs2_data == '0));

endmodule

// File: riscv_consts.svh
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// machine word and register file size
`define XLEN      32
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC  32'h0000_0000

// sequential advance of the pc
`define PC_STEP   32'd4

// major opcodes, inst[6:0]
`define OP_REG    7'b0110011
`define OP_IMM    7'b0010011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_BRANCH 7'b1100011
`define OP_SYSTEM 7'b1110011

`endif

// File: riscv_core.sv
`timescale 1ns/1ps

module riscv_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_ack,
    input  riscv_pkg::word_t    inst,
    output logic                fetch_req,
    output riscv_pkg::word_t    fetch_addr,
    output logic                retire_valid,
    output riscv_pkg::word_t    retire_pc,
    output logic                retire_we,
    output riscv_pkg::reg_idx_t retire_rd,
    output riscv_pkg::word_t    retire_data,
    output logic                halted
);
    import riscv_pkg::*;

    word_t    inst_reg;
    word_t    pc;
    reg_idx_t rs1_num;
    reg_idx_t rs2_num;
    reg_idx_t rd_num;
    word_t    imm;
    alu_op_t  alu_op;
    logic     src_a_pc;
    logic     src_b_imm;
    logic     writes_rd;
    logic     is_branch;
    logic     is_system;
    funct3_t  funct3;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    logic     branch_taken;
    word_t    branch_target;
    logic     rd_we;
    word_t    rd_data;

    core_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_ack     (fetch_ack),
        .inst          (inst),
        .alu_result    (alu_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .writes_rd     (writes_rd),
        .is_system     (is_system),
        .rd_num        (rd_num),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .inst_reg      (inst_reg),
        .pc            (pc),
        .rd_we         (rd_we),
        .rd_data       (rd_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_we     (retire_we),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .halted        (halted)
    );

    instr_decode u_decode (
        .inst      (inst_reg),
        .rs1_num   (rs1_num),
        .rs2_num   (rs2_num),
        .rd_num    (rd_num),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_a_pc  (src_a_pc),
        .src_b_imm (src_b_imm),
        .writes_rd (writes_rd),
        .is_branch (is_branch),
        .is_system (is_system),
        .funct3    (funct3)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_num  (rs1_num),
        .rs2_num  (rs2_num),
        .rd_num   (rd_num),
        .rd_we    (rd_we),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .imm        (imm),
        .src_a_pc   (src_a_pc),
        .src_b_imm  (src_b_imm),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    branch_unit u_branch (
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .pc            (pc),
        .imm           (imm),
        .funct3        (funct3),
        .is_branch     (is_branch),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

// File: riscv_pkg.sv
`include "riscv_consts.svh"

package riscv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    typedef logic [2:0] funct3_t;

    // PASS_B forwards operand b untouched, used by lui
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_RELEASE,
        EXECUTE,
        HALT
    } ctrl_state_t;

endpackage

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_riscv_core \
    -f filelist.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #20;
        clk = ~clk;
    end

endmodule

// File: tb_riscv_core.sv
`timescale 1ns/1ps
`include "riscv_consts.svh"

module tb_riscv_core;

    localparam int MAX_ROWS     = 64;
    localparam int RESET_CYCLES = 2;

    logic        clk;
    logic        rst_n;
    logic        fetch_ack;
    logic [31:0] inst;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        halted;

    // one row per executed instruction, in program order
    string       row_name [MAX_ROWS];
    logic [31:0] row_pc   [MAX_ROWS];
    logic        row_we   [MAX_ROWS];
    int          row_rd   [MAX_ROWS];
    logic [31:0] row_data [MAX_ROWS];
    logic [31:0] row_next [MAX_ROWS];
    logic [31:0] imem     [64];

    integer seed;
    int     ack_delay;
    int     release_delay;
    int     n_rows         = 0;
    int     cycles         = 0;
    int     timeout_cycles = 0;
    int     row_errors     = 0;
    int     pass_count     = 0;
    int     fail_count     = 0;
    int     other_errors   = 0;
    int     retire_count   = 0;

    tb_clock_gen u_clk_gen (
        .clk (clk)
    );

    riscv_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_ack    (fetch_ack),
        .inst         (inst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    function automatic logic [31:0] reg_op(input int funct7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {funct7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OP_REG};
    endfunction

    function automatic logic [31:0] imm_op(input int imm, input int rs1, input int f3,
                                           input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `OP_IMM};
    endfunction

    function automatic logic [31:0] upper_op(input int imm, input int rd,
                                             input logic [6:0] opcode);
        return {imm[19:0], rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] branch_op(input int off, input int rs2, input int rs1,
                                              input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                `OP_BRANCH};
    endfunction

    // step is the pc advance the ISA gives for this instruction
    task automatic add_row(input string name, input logic [31:0] word, input logic we,
                           input int rd, input logic [31:0] data, input int step);
        logic [31:0] pc_here;
        pc_here = (n_rows == 0) ? `RESET_PC : row_next[n_rows-1];
        row_name[n_rows] = name;
        row_pc[n_rows]   = pc_here;
        row_we[n_rows]   = we;
        row_rd[n_rows]   = rd;
        row_data[n_rows] = data;
        row_next[n_rows] = pc_here + step;
        imem[pc_here[7:2]] = word;
        n_rows++;
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s expected %h got %h", name, expected, actual);
            row_errors++;
        end
    endtask

    // instruction memory with a random ack delay of 0 to 3 cycles
    initial begin
        fetch_ack = 1'b0;
        inst      = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (fetch_req && !fetch_ack) begin
                ack_delay = $unsigned($random(seed)) % 4;
                for (int i = 0; i < ack_delay; i++) begin
                    @(posedge clk);
                    #1;
                end
                inst      = imem[fetch_addr[7:2]];
                fetch_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (fetch_req);
                // memory may keep ack high one cycle longer
                release_delay = $unsigned($random(seed)) % 2;
                for (int i = 0; i < release_delay; i++) begin
                    @(posedge clk);
                    #1;
                end
                fetch_ack = 1'b0;
            end
        end
    end

    always @(posedge fetch_req) begin
        if (rst_n === 1'b1) begin
            assert (fetch_ack === 1'b0) else begin
                $display("fetch_req rose while fetch_ack was still high at %0t", $time);
                other_errors++;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            retire_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (timeout_cycles > 0 && cycles > timeout_cycles) begin
            $display("run timed out after %0d cycles with %0d of %0d instructions retired",
                     cycles, retire_count, n_rows);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed  = 32'h7ddd;
        rst_n = 1'b0;
        // unused words decode as no-ops
        for (int i = 0; i < 64; i++) begin
            imem[i] = {i[24:0], 7'b0};
        end

        // immediate group, x1 = -5 and x2 = 12
        add_row("addi",  imm_op(-5, 0, 0, 1),    1'b1, 1,  32'hFFFF_FFFB, 4);
        add_row("addi",  imm_op(12, 0, 0, 2),    1'b1, 2,  32'h0000_000C, 4);
        add_row("slti",  imm_op(-4, 1, 2, 3),    1'b1, 3,  32'h0000_0001, 4);
        add_row("sltiu", imm_op(-4, 1, 3, 4),    1'b1, 4,  32'h0000_0001, 4);
        add_row("xori",  imm_op(-1, 2, 4, 5),    1'b1, 5,  32'hFFFF_FFF3, 4);
        add_row("ori",   imm_op(3, 2, 6, 6),     1'b1, 6,  32'h0000_000F, 4);
        add_row("andi",  imm_op(-16, 1, 7, 7),   1'b1, 7,  32'hFFFF_FFF0, 4);
        add_row("addi",  imm_op(7, 2, 0, 0),     1'b1, 0,  32'h0000_0013, 4);
        // x0 must still read zero here
        add_row("add",   reg_op(0, 2, 0, 0, 8),  1'b1, 8,  32'h0000_000C, 4);
        add_row("slli",  imm_op(4, 2, 1, 9),     1'b1, 9,  32'h0000_00C0, 4);
        add_row("srli",  imm_op(28, 1, 5, 10),   1'b1, 10, 32'h0000_000F, 4);
        add_row("srai",  imm_op(1025, 1, 5, 11), 1'b1, 11, 32'hFFFF_FFFD, 4);

        // register group
        add_row("add",  reg_op(0, 2, 1, 0, 12),  1'b1, 12, 32'h0000_0007, 4);
        add_row("sub",  reg_op(32, 2, 1, 0, 13), 1'b1, 13, 32'hFFFF_FFEF, 4);
        add_row("sll",  reg_op(0, 6, 2, 1, 14),  1'b1, 14, 32'h0006_0000, 4);
        add_row("slt",  reg_op(0, 2, 1, 2, 15),  1'b1, 15, 32'h0000_0001, 4);
        add_row("sltu", reg_op(0, 2, 1, 3, 16),  1'b1, 16, 32'h0000_0000, 4);
        add_row("xor",  reg_op(0, 2, 1, 4, 17),  1'b1, 17, 32'hFFFF_FFF7, 4);
        add_row("srl",  reg_op(0, 3, 1, 5, 18),  1'b1, 18, 32'h7FFF_FFFD, 4);
        add_row("sra",  reg_op(32, 3, 1, 5, 19), 1'b1, 19, 32'hFFFF_FFFD, 4);
        add_row("or",   reg_op(0, 2, 1, 6, 20),  1'b1, 20, 32'hFFFF_FFFF, 4);
        add_row("and",  reg_op(0, 2, 1, 7, 21),  1'b1, 21, 32'h0000_0008, 4);

        add_row("lui",   upper_op(32'h12345, 22, `OP_LUI), 1'b1, 22, 32'h1234_5000, 4);
        // pc is 0x5c
        add_row("auipc", upper_op(1, 23, `OP_AUIPC),       1'b1, 23, 32'h0000_105C, 4);

        // each condition taken, then not taken
        add_row("beq",  branch_op(8, 8, 2, 0), 1'b0, 0, '0, 8);
        add_row("beq",  branch_op(8, 2, 1, 0), 1'b0, 0, '0, 4);
        add_row("bne",  branch_op(8, 2, 1, 1), 1'b0, 0, '0, 8);
        add_row("bne",  branch_op(8, 8, 2, 1), 1'b0, 0, '0, 4);
        add_row("blt",  branch_op(8, 2, 1, 4), 1'b0, 0, '0, 8);
        add_row("blt",  branch_op(8, 1, 2, 4), 1'b0, 0, '0, 4);
        add_row("bge",  branch_op(8, 1, 2, 5), 1'b0, 0, '0, 8);
        add_row("bge",  branch_op(8, 2, 1, 5), 1'b0, 0, '0, 4);
        add_row("bltu", branch_op(8, 1, 2, 6), 1'b0, 0, '0, 8);
        add_row("bltu", branch_op(8, 2, 1, 6), 1'b0, 0, '0, 4);
        add_row("bgeu", branch_op(8, 2, 1, 7), 1'b0, 0, '0, 8);
        add_row("bgeu", branch_op(8, 1, 2, 7), 1'b0, 0, '0, 4);

        // two-pass loop closed by a backward bne
        add_row("addi", imm_op(2, 0, 0, 25),       1'b1, 25, 32'h0000_0002, 4);
        add_row("addi", imm_op(1, 24, 0, 24),      1'b1, 24, 32'h0000_0001, 4);
        add_row("bne",  branch_op(-4, 25, 24, 1),  1'b0, 0,  '0,            -4);
        add_row("addi", imm_op(1, 24, 0, 24),      1'b1, 24, 32'h0000_0002, 4);
        add_row("bne",  branch_op(-4, 25, 24, 1),  1'b0, 0,  '0,            4);
        add_row("ecall", {25'b0, `OP_SYSTEM},      1'b0, 0,  '0,            4);

        timeout_cycles = n_rows * (3 + 4) + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            row_errors = 0;
            do begin
                @(negedge clk);
            end while (!retire_valid);
            check_field("retire_pc", row_pc[r], retire_pc);
            check_field("retire_we", 32'(row_we[r]), 32'(retire_we));
            if (row_we[r]) begin
                check_field("retire_rd", row_rd[r], 32'(retire_rd));
                check_field("retire_data", row_data[r], retire_data);
            end
            if (r < n_rows - 1) begin
                do begin
                    @(negedge clk);
                end while (!fetch_req);
                check_field("fetch_addr", row_next[r], fetch_addr);
            end else begin
                // last row is the system opcode
                repeat (5) begin
                    @(negedge clk);
                    assert (halted && !fetch_req) else begin
                        $display("core did not stay halted after the system instruction");
                        row_errors++;
                    end
                end
            end
            if (row_errors == 0) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("row %0d %s at pc %h %s", r, row_name[r], row_pc[r],
                     (row_errors == 0) ? "ok" : "failed");
        end

        @(posedge clk);
        assert (retire_count == n_rows) else begin
            $display("core retired %0d instructions instead of %0d", retire_count, n_rows);
            other_errors++;
        end
        $display("rows passed %0d failed %0d, other errors %0d",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
